// ==== source/kbd_soc_defines.svh ====
`ifndef KBD_SOC_DEFINES_SVH
`define KBD_SOC_DEFINES_SVH

// Address map, 16-bit bus addresses
`define RAM_BASE      16'h0000
`define KEY_ADDR      16'h1000
`define UART_ADDR     16'h1004

// RAM depth in 32-bit words, 1 KB in total
`define RAM_WORDS     256

// Start, eight data bits, parity, stop
`define PS2_FRAME_BITS 11

// Set-2 prefix bytes
`define SCAN_BREAK    8'hF0
`define SCAN_EXTENDED 8'hE0

// Interrupt vector raised for a key press
`define IRQ_KEYBOARD  4'd1

`endif

// ==== source/kbd_soc_pkg.sv ====
package kbd_soc_pkg;

    // PS/2 frame receiver
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    // Prefix bytes seen ahead of a scan code
    typedef enum logic [1:0] {
        PFX_NONE,
        PFX_BREAK,
        PFX_EXTENDED,
        PFX_EXT_BREAK
    } prefix_state_e;

    // Bus address decode
    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_KEY,
        REGION_UART,
        REGION_NONE
    } bus_region_e;

endpackage

// ==== source/ps2_receiver.sv ====
`timescale 1ns/1ps
`include "kbd_soc_defines.svh"

module ps2_receiver (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       frame_error
);

    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       clk_fall;
    logic [3:0] bit_count;
    logic [7:0] shift_reg;
    logic       start_ok;
    logic       parity_ok;
    logic       frame_good;
    kbd_soc_pkg::rx_state_e state;

    // Both PS/2 lines idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // Device drives data while the PS/2 clock is high, so sample on the fall
    assign clk_fall   = clk_prev & ~clk_sync[1];
    assign frame_good = start_ok & parity_ok & dat_sync[1];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state       <= kbd_soc_pkg::RX_IDLE;
            bit_count   <= 4'd0;
            start_ok    <= 1'b0;
            parity_ok   <= 1'b0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
            if (clk_fall) begin
                case (state)
                    kbd_soc_pkg::RX_IDLE: begin
                        // A bad start bit is carried to the end of the frame
                        start_ok  <= ~dat_sync[1];
                        bit_count <= 4'd1;
                        state     <= kbd_soc_pkg::RX_DATA;
                    end
                    kbd_soc_pkg::RX_DATA: begin
                        bit_count <= bit_count + 4'd1;
                        if (bit_count == 4'(`PS2_FRAME_BITS - 3)) begin
                            state <= kbd_soc_pkg::RX_PARITY;
                        end
                    end
                    kbd_soc_pkg::RX_PARITY: begin
                        // Odd parity over data and parity bit
                        parity_ok <= ^{shift_reg, dat_sync[1]};
                        state     <= kbd_soc_pkg::RX_STOP;
                    end
                    kbd_soc_pkg::RX_STOP: begin
                        rx_valid    <= frame_good;
                        frame_error <= ~frame_good;
                        state       <= kbd_soc_pkg::RX_IDLE;
                    end
                endcase
            end
        end
    end

    // LSB first
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall && state == kbd_soc_pkg::RX_DATA) begin
            shift_reg <= {dat_sync[1], shift_reg[7:1]};
        end
        if (clk_fall && state == kbd_soc_pkg::RX_STOP && frame_good) begin
            rx_byte <= shift_reg;
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        rx_valid |-> !frame_error && state == kbd_soc_pkg::RX_IDLE);

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        rx_valid |=> !rx_valid);

endmodule

// ==== source/ps2_keymap.sv ====
`timescale 1ns/1ps
`include "kbd_soc_defines.svh"

module ps2_keymap (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    output logic       key_valid,
    output logic [7:0] key_scan,
    output logic [7:0] key_ascii,
    output logic       key_extended,
    output logic       key_released
);

    kbd_soc_pkg::prefix_state_e prefix;
    logic is_extended;
    logic is_released;
    logic is_prefix;

    // Set-2 make codes to ASCII, everything else is 0
    function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
        case (code)
            8'h1C: return "a";
            8'h32: return "b";
            8'h21: return "c";
            8'h23: return "d";
            8'h24: return "e";
            8'h2B: return "f";
            8'h34: return "g";
            8'h33: return "h";
            8'h43: return "i";
            8'h3B: return "j";
            8'h42: return "k";
            8'h4B: return "l";
            8'h3A: return "m";
            8'h31: return "n";
            8'h44: return "o";
            8'h4D: return "p";
            8'h15: return "q";
            8'h2D: return "r";
            8'h1B: return "s";
            8'h2C: return "t";
            8'h3C: return "u";
            8'h2A: return "v";
            8'h1D: return "w";
            8'h22: return "x";
            8'h35: return "y";
            8'h1A: return "z";
            8'h45: return "0";
            8'h16: return "1";
            8'h1E: return "2";
            8'h26: return "3";
            8'h25: return "4";
            8'h2E: return "5";
            8'h36: return "6";
            8'h3D: return "7";
            8'h3E: return "8";
            8'h46: return "9";
            8'h29: return 8'h20;
            8'h5A: return 8'h0D;
            default: return 8'h00;
        endcase
    endfunction

    assign is_extended = (prefix == kbd_soc_pkg::PFX_EXTENDED) ||
                         (prefix == kbd_soc_pkg::PFX_EXT_BREAK);
    assign is_released = (prefix == kbd_soc_pkg::PFX_BREAK) ||
                         (prefix == kbd_soc_pkg::PFX_EXT_BREAK);
    assign is_prefix   = (rx_byte == `SCAN_BREAK) || (rx_byte == `SCAN_EXTENDED);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            prefix    <= kbd_soc_pkg::PFX_NONE;
            key_valid <= 1'b0;
        end else begin
            key_valid <= rx_valid & ~is_prefix;
            if (rx_valid) begin
                if (rx_byte == `SCAN_BREAK) begin
                    prefix <= is_extended ? kbd_soc_pkg::PFX_EXT_BREAK
                                          : kbd_soc_pkg::PFX_BREAK;
                end else if (rx_byte == `SCAN_EXTENDED) begin
                    prefix <= is_released ? kbd_soc_pkg::PFX_EXT_BREAK
                                          : kbd_soc_pkg::PFX_EXTENDED;
                end else begin
                    prefix <= kbd_soc_pkg::PFX_NONE;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rx_valid && !is_prefix) begin
            key_scan     <= rx_byte;
            key_ascii    <= is_extended ? 8'h00 : scan_to_ascii(rx_byte);
            key_extended <= is_extended;
            key_released <= is_released;
        end
    end

endmodule

// ==== source/key_irq_controller.sv ====
`timescale 1ns/1ps
`include "kbd_soc_defines.svh"

module key_irq_controller (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic        key_valid,
    input  logic [7:0]  key_scan,
    input  logic [7:0]  key_ascii,
    input  logic        key_extended,
    input  logic        key_released,
    input  logic        interrupt_ack,
    output logic [31:0] key_data,
    output logic [3:0]  interrupt_vector,
    output logic        irq_led
);

    logic key_press;

    // Only printable presses interrupt the CPU
    assign key_press = key_valid & ~key_released & (key_ascii != 8'h00);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_data         <= 32'd0;
            interrupt_vector <= 4'd0;
        end else begin
            if (key_valid) begin
                key_data <= {14'd0, key_released, key_extended, key_scan, key_ascii};
            end
            // A press arriving with the acknowledge stays pending
            if (key_press) begin
                interrupt_vector <= `IRQ_KEYBOARD;
            end else if (interrupt_vector != 4'd0 && interrupt_ack) begin
                interrupt_vector <= 4'd0;
            end
        end
    end

    assign irq_led = (interrupt_vector != 4'd0);

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        interrupt_vector == 4'd0 || interrupt_vector == `IRQ_KEYBOARD);

endmodule

// ==== source/soc_bus.sv ====
`timescale 1ns/1ps
`include "kbd_soc_defines.svh"

module soc_bus (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic [15:0] bus_address,
    input  logic [31:0] bus_write_data,
    input  logic        bus_write_enable,
    input  logic        bus_read_enable,
    output logic [31:0] bus_read_data,
    input  logic [31:0] key_data,
    output logic [7:0]  uart_tx_data,
    output logic        uart_tx_valid
);

    localparam int          RAM_AW    = $clog2(`RAM_WORDS);
    localparam logic [15:0] RAM_BYTES = 16'(`RAM_WORDS * 4);

    logic [31:0] ram [`RAM_WORDS];
    logic [RAM_AW-1:0] ram_index;
    logic uart_write;
    logic uart_write_d;
    kbd_soc_pkg::bus_region_e region;

    always_comb begin
        if (bus_address >= `RAM_BASE && bus_address < `RAM_BASE + RAM_BYTES) begin
            region = kbd_soc_pkg::REGION_RAM;
        end else if (bus_address == `KEY_ADDR) begin
            region = kbd_soc_pkg::REGION_KEY;
        end else if (bus_address == `UART_ADDR) begin
            region = kbd_soc_pkg::REGION_UART;
        end else begin
            region = kbd_soc_pkg::REGION_NONE;
        end
    end

    // Word addressed, byte offset dropped
    assign ram_index = bus_address[RAM_AW+1:2];

    // Write wins over read, read data holds between reads
    always_ff @(posedge CLOCK_50) begin
        if (bus_write_enable) begin
            if (region == kbd_soc_pkg::REGION_RAM) begin
                ram[ram_index] <= bus_write_data;
            end
        end else if (bus_read_enable) begin
            case (region)
                kbd_soc_pkg::REGION_RAM: bus_read_data <= ram[ram_index];
                kbd_soc_pkg::REGION_KEY: bus_read_data <= key_data;
                default:                 bus_read_data <= 32'd0;
            endcase
        end
    end

    // Console strobe on the first cycle of a write run
    assign uart_write = bus_write_enable & (region == kbd_soc_pkg::REGION_UART);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_write_d  <= 1'b0;
            uart_tx_valid <= 1'b0;
        end else begin
            uart_write_d  <= uart_write;
            uart_tx_valid <= uart_write & ~uart_write_d;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (uart_write && !uart_write_d) begin
            uart_tx_data <= bus_write_data[7:0];
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_tx_valid |=> !uart_tx_valid);

endmodule

// ==== source/kbd_soc_top.sv ====
`timescale 1ns/1ps

module kbd_soc_top (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic        ps2_clk,
    input  logic        ps2_dat,
    input  logic [15:0] bus_address,
    input  logic [31:0] bus_write_data,
    input  logic        bus_write_enable,
    input  logic        bus_read_enable,
    output logic [31:0] bus_read_data,
    output logic [3:0]  interrupt_vector,
    input  logic        interrupt_ack,
    output logic [7:0]  uart_tx_data,
    output logic        uart_tx_valid,
    output logic [7:0]  ledg,
    output logic        ledr0
);

    logic [7:0]  rx_byte;
    logic        rx_valid;
    logic        key_valid;
    logic [7:0]  key_scan;
    logic [7:0]  key_ascii;
    logic        key_extended;
    logic        key_released;
    logic [31:0] key_data;

    // Bad frames never reach the keymap
    ps2_receiver u_receiver (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .ps2_clk     (ps2_clk),
        .ps2_dat     (ps2_dat),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .frame_error ()
    );

    ps2_keymap u_keymap (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .key_valid    (key_valid),
        .key_scan     (key_scan),
        .key_ascii    (key_ascii),
        .key_extended (key_extended),
        .key_released (key_released)
    );

    key_irq_controller u_irq (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .key_valid        (key_valid),
        .key_scan         (key_scan),
        .key_ascii        (key_ascii),
        .key_extended     (key_extended),
        .key_released     (key_released),
        .interrupt_ack    (interrupt_ack),
        .key_data         (key_data),
        .interrupt_vector (interrupt_vector),
        .irq_led          (ledr0)
    );

    soc_bus u_bus (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .key_data         (key_data),
        .uart_tx_data     (uart_tx_data),
        .uart_tx_valid    (uart_tx_valid)
    );

    // Last key's ASCII on the green LEDs
    assign ledg = key_data[7:0];

endmodule

// ==== tb/kbd_soc_tb.sv ====
`timescale 1ns/1ps
`include "kbd_soc_defines.svh"

module kbd_soc_tb;

    localparam int NUM_KEYS     = 9;
    localparam int MAX_BYTES    = 3;
    localparam int HALF_PS2     = 5;
    localparam int SETTLE       = 10;
    localparam int RAM_OPS      = 20;
    localparam int FRAME_CYCLES = `PS2_FRAME_BITS * 2 * HALF_PS2 + SETTLE;
    localparam int WATCHDOG_CYCLES = NUM_KEYS * MAX_BYTES * FRAME_CYCLES + NUM_KEYS * 10
                                   + RAM_OPS * 4 + 20 + 500;

    logic        CLOCK_50;
    logic        KEY0;
    logic        ps2_clk;
    logic        ps2_dat;
    logic [15:0] bus_address;
    logic [31:0] bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    logic [31:0] bus_read_data;
    logic [3:0]  interrupt_vector;
    logic        interrupt_ack;
    logic [7:0]  uart_tx_data;
    logic        uart_tx_valid;
    logic [7:0]  ledg;
    logic        ledr0;

    // Key table of bytes sent, bad parity on the last byte, expected key register and interrupt
    logic [7:0]  key_seq [NUM_KEYS][MAX_BYTES];
    int          key_len [NUM_KEYS];
    bit          key_bad [NUM_KEYS];
    logic [31:0] key_exp [NUM_KEYS];
    bit          key_irq [NUM_KEYS];
    int          num_loaded;

    logic [31:0] lcg_state;
    logic [31:0] ram_model [`RAM_WORDS];
    logic [15:0] ram_addr_list [RAM_OPS];

    kbd_soc_top u_dut (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .ps2_clk          (ps2_clk),
        .ps2_dat          (ps2_dat),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .uart_tx_data     (uart_tx_data),
        .uart_tx_valid    (uart_tx_valid),
        .ledg             (ledg),
        .ledr0            (ledr0)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
        $display("Timeout: the simulation ran longer than the tests should take");
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s: expected %h, actual %h", $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic add_key(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2,
                           input int len, input bit bad, input logic [31:0] exp,
                           input bit irq);
        key_seq[num_loaded][0] = b0;
        key_seq[num_loaded][1] = b1;
        key_seq[num_loaded][2] = b2;
        key_len[num_loaded]    = len;
        key_bad[num_loaded]    = bad;
        key_exp[num_loaded]    = exp;
        key_irq[num_loaded]    = irq;
        num_loaded++;
    endtask

    // Start, data LSB first, odd parity and stop bits
    // Data changes while the PS/2 clock is high
    task automatic send_frame(input logic [7:0] data, input bit bad_parity);
        logic [10:0] frame;
        int i;
        frame = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
        for (i = 0; i < `PS2_FRAME_BITS; i++) begin
            ps2_dat = frame[i];
            repeat (HALF_PS2) @(negedge CLOCK_50);
            ps2_clk = 1'b0;
            repeat (HALF_PS2) @(negedge CLOCK_50);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        // Covers synchronizer, receiver, keymap and key register latency
        repeat (SETTLE) @(negedge CLOCK_50);
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
        bus_address     = addr;
        bus_read_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_read_enable = 1'b0;
        data = bus_read_data;
    endtask

    task automatic run_key_table();
        logic [31:0] rd;
        int k;
        int b;
        for (k = 0; k < num_loaded; k++) begin
            for (b = 0; b < key_len[k]; b++) begin
                send_frame(key_seq[k][b], key_bad[k] && (b == key_len[k] - 1));
            end
            check_value("interrupt_vector", interrupt_vector,
                        key_irq[k] ? `IRQ_KEYBOARD : 4'd0);
            check_value("ledr0", ledr0, key_irq[k]);
            bus_read(`KEY_ADDR, rd);
            check_value("key_data", rd, key_exp[k]);
            check_value("ledg", ledg, key_exp[k][7:0]);
            if (key_irq[k]) begin
                interrupt_ack = 1'b1;
                @(negedge CLOCK_50);
                interrupt_ack = 1'b0;
                check_value("interrupt_vector", interrupt_vector, 4'd0);
                check_value("ledr0", ledr0, 1'b0);
            end
        end
    endtask

    task automatic run_ram_test();
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] rd;
        int i;
        for (i = 0; i < RAM_OPS; i++) begin
            r = lcg_next();
            data = lcg_next();
            ram_addr_list[i] = {6'd0, r[23:16], 2'b00};
            ram_model[r[23:16]] = data;
            bus_write(ram_addr_list[i], data);
        end
        for (i = 0; i < RAM_OPS; i++) begin
            bus_read(ram_addr_list[i], rd);
            check_value("bus_read_data", rd, ram_model[ram_addr_list[i][9:2]]);
        end
        // Nothing is mapped here
        bus_read(16'h2000, rd);
        check_value("bus_read_data", rd, 32'd0);
    endtask

    task automatic run_uart_test();
        int i;
        int pulses;
        int pulse_cycle;
        logic [7:0] tx_byte;
        pulses = 0;
        pulse_cycle = -1;
        tx_byte = 8'h00;
        for (i = 0; i < 8; i++) begin
            bus_address      = `UART_ADDR;
            bus_write_data   = 32'hA5A5_5541 + i;
            bus_write_enable = (i < 3);
            @(negedge CLOCK_50);
            if (uart_tx_valid) begin
                pulses++;
                pulse_cycle = i;
                tx_byte = uart_tx_data;
            end
        end
        check_value("uart_tx_valid pulses", pulses, 1);
        check_value("uart_tx_valid cycle", pulse_cycle, 0);
        check_value("uart_tx_data", tx_byte, 8'h41);
    endtask

    initial begin
        logic [31:0] rd;
        KEY0             = 1'b0;
        ps2_clk          = 1'b1;
        ps2_dat          = 1'b1;
        bus_address      = 16'h0000;
        bus_write_data   = 32'd0;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        interrupt_ack    = 1'b0;
        lcg_state        = 32'd61;
        num_loaded       = 0;

        // Letters, digit, space, break, unmapped, two extended, bad parity, enter
        add_key(8'h1C, 8'h00, 8'h00, 1, 1'b0, 32'h0000_1C61, 1'b1);
        add_key(8'h16, 8'h00, 8'h00, 1, 1'b0, 32'h0000_1631, 1'b1);
        add_key(8'h29, 8'h00, 8'h00, 1, 1'b0, 32'h0000_2920, 1'b1);
        add_key(`SCAN_BREAK, 8'h1C, 8'h00, 2, 1'b0, 32'h0002_1C61, 1'b0);
        add_key(8'h12, 8'h00, 8'h00, 1, 1'b0, 32'h0000_1200, 1'b0);
        add_key(`SCAN_EXTENDED, 8'h75, 8'h00, 2, 1'b0, 32'h0001_7500, 1'b0);
        add_key(`SCAN_EXTENDED, 8'h5A, 8'h00, 2, 1'b0, 32'h0001_5A00, 1'b0);
        add_key(8'h5A, 8'h00, 8'h00, 1, 1'b1, 32'h0001_5A00, 1'b0);
        add_key(8'h5A, 8'h00, 8'h00, 1, 1'b0, 32'h0000_5A0D, 1'b1);

        repeat (4) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        @(negedge CLOCK_50);

        check_value("interrupt_vector", interrupt_vector, 4'd0);
        check_value("ledr0", ledr0, 1'b0);
        check_value("uart_tx_valid", uart_tx_valid, 1'b0);
        bus_read(`KEY_ADDR, rd);
        check_value("key_data", rd, 32'd0);

        run_key_table();
        run_ram_test();
        run_uart_test();

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== kbd_soc.f ====
+incdir+source
source/kbd_soc_pkg.sv
source/ps2_receiver.sv
source/ps2_keymap.sv
source/key_irq_controller.sv
source/soc_bus.sv
source/kbd_soc_top.sv
tb/kbd_soc_tb.sv
